/* src.f */
+incdir+test
hw/xform_pkg.sv
hw/xform_ctrl.sv
hw/vec_elementwise.sv
hw/dot_product.sv
hw/quat_mult.sv
hw/quat_rotate.sv
hw/xform_unit.sv
test/xform_tb.sv

/* Makefile */
SIM := obj_dir/Vxform_tb

.PHONY: all run clean

all: run

$(SIM): src.f $(wildcard hw/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)
	verilator --binary --timing --assert -j 0 --top-module xform_tb -f src.f -o Vxform_tb

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* test/xform_ref.svh */
`ifndef XFORM_REF_SVH
`define XFORM_REF_SVH

// q8.8 product at full width, arithmetic shift, low 16 bits kept
function automatic fix16_t ref_mul(input fix16_t x, input fix16_t y);
    int wide;
    wide = int'(x) * int'(y);
    wide = wide >>> FRAC_BITS;
    return wide[15:0];
endfunction

// hamilton product, pairs summed first as in the datapath
function automatic quat_t ref_hamilton(input quat_t p, input quat_t q);
    quat_t  c;
    fix16_t lo;
    fix16_t hi;
    lo   = ref_mul(p[0], q[0]) - ref_mul(p[1], q[1]);
    hi   = ref_mul(p[2], q[2]) + ref_mul(p[3], q[3]);
    c[0] = lo - hi;                                  // real
    lo   = ref_mul(p[0], q[1]) + ref_mul(p[1], q[0]);
    hi   = ref_mul(p[2], q[3]) - ref_mul(p[3], q[2]);
    c[1] = lo + hi;                                  // i
    lo   = ref_mul(p[0], q[2]) - ref_mul(p[1], q[3]);
    hi   = ref_mul(p[2], q[0]) + ref_mul(p[3], q[1]);
    c[2] = lo + hi;                                  // j
    lo   = ref_mul(p[0], q[3]) + ref_mul(p[1], q[2]);
    hi   = ref_mul(p[2], q[1]) - ref_mul(p[3], q[0]);
    c[3] = lo - hi;                                  // k
    return c;
endfunction

// q * (0,v) * conj(q), vector part only
function automatic vec3_t ref_rotate(input vec3_t v, input quat_t q);
    quat_t pv;
    quat_t qc;
    quat_t t;
    vec3_t y;
    pv[0] = '0;
    qc[0] = q[0];
    for (int i = 0; i < 3; i++) begin
        pv[i+1] = v[i];
        qc[i+1] = -q[i+1];                           // 16 bit wrap
    end
    t = ref_hamilton(ref_hamilton(q, pv), qc);
    for (int i = 0; i < 3; i++) begin
        y[i] = t[i+1];
    end
    return y;
endfunction

// expected result word for any opcode
function automatic vec3_t ref_result(input xform_op_e o, input vec3_t va, input vec3_t vb,
                                     input quat_t q);
    vec3_t y;
    y = '0;
    case (o)
        OP_SCALE: begin
            for (int i = 0; i < 3; i++) y[i] = ref_mul(va[i], vb[i]);
        end
        OP_TRANSLATE: begin
            for (int i = 0; i < 3; i++) y[i] = va[i] + vb[i];
        end
        OP_DOT: begin
            y[0] = ref_mul(va[0], vb[0]) + ref_mul(va[1], vb[1]);
            y[0] = y[0] + ref_mul(va[2], vb[2]);     // z added last
        end
        default: y = ref_rotate(va, q);
    endcase
    return y;
endfunction

// galois lfsr x^16+x^14+x^13+x^11+1, shifting right
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

`endif

/* test/xform_tb.sv */
`timescale 1ns/1ps

module xform_tb;
    import xform_pkg::*;

    `include "xform_ref.svh"

    localparam int MUL_STAGES  = 2;
    localparam int ADD_STAGES  = 1;
    localparam int LAT_ELEM    = MUL_STAGES;
    localparam int LAT_DOT     = MUL_STAGES + 2 * ADD_STAGES;
    localparam int LAT_QMUL    = MUL_STAGES + 2 * ADD_STAGES;
    localparam int LAT_ROT     = 2 * LAT_QMUL;
    localparam int DRAIN_LIMIT = 4 * LAT_ROT + 20;   // cycles before giving up

    typedef struct packed {
        int        due;                              // cycle count where done shows
        xform_op_e op;
        vec3_t     vec;
    } expect_t;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        valid_in;
    xform_op_e   op;
    vec3_t       a;
    vec3_t       b;
    quat_t       rot;
    logic        done;
    logic        reject;
    xform_op_e   result_op;
    vec3_t       result;

    int          cyc = 0;                            // posedge count
    logic [15:0] lfsr = 16'd19771;
    expect_t     exp_q [$];                          // accepted ops in flight
    int          rej_q [$];                          // cycles where reject is due
    string       test_name = "reset";
    int          errors = 0;                         // written by compare process only
    int          checks = 0;
    int          tb_faults = 0;                      // timeouts and missing rejects
    int          err_mark = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          predicted_rejects = 0;
    int          seen_rejects = 0;                   // reject pulses from the DUT

    always #20 clk = ~clk;                           // 40 ns period

    always @(posedge clk) cyc <= cyc + 1;

    xform_unit #(
        .MUL_STAGES (MUL_STAGES),
        .ADD_STAGES (ADD_STAGES)
    ) dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid_in  (valid_in),
        .op        (op),
        .a         (a),
        .b         (b),
        .rot       (rot),
        .done      (done),
        .reject    (reject),
        .result_op (result_op),
        .result    (result)
    );

    function automatic int latency_of(input xform_op_e o);
        case (o)
            OP_SCALE, OP_TRANSLATE: return LAT_ELEM;
            OP_DOT:                 return LAT_DOT;
            default:                return LAT_ROT;
        endcase
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};               // one step per bit
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic fix16_t rand_signed(input int n);
        fix16_t r;
        r = rand_bits(n) << (16 - n);
        return r >>> (16 - n);                       // sign extend n bits
    endfunction

    task automatic random_operands(output vec3_t va, output vec3_t vb, output quat_t q);
        for (int i = 0; i < 3; i++) begin
            va[i] = rand_signed(12);                 // about +-8.0
            vb[i] = rand_signed(16);
        end
        for (int i = 0; i < 4; i++) begin
            q[i] = rand_signed(9);                   // about +-1.0
        end
    endtask

    // drive one op and predict its outcome from the completion slot rule
    task automatic issue(input xform_op_e o, input vec3_t va, input vec3_t vb, input quat_t q);
        int      due;
        logic    taken;
        expect_t e;
        @(posedge clk);
        valid_in <= 1'b1;
        op       <= o;
        a        <= va;
        b        <= vb;
        rot      <= q;
        due   = cyc + 2 + latency_of(o);
        taken = 1'b0;
        foreach (exp_q[i]) begin
            if (exp_q[i].due == due) taken = 1'b1;
        end
        if (taken) begin
            rej_q.push_back(cyc + 1);                // same cycle as valid_in
            predicted_rejects++;
        end else begin
            e.due = due;
            e.op  = o;
            e.vec = ref_result(o, va, vb, q);
            exp_q.push_back(e);
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        valid_in <= 1'b0;
    endtask

    task automatic drain();
        int n;
        idle_cycle();
        n = 0;
        while ((exp_q.size() != 0 || rej_q.size() != 0) && n < DRAIN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0 || rej_q.size() != 0) begin
            $display("Timeout in %s: %0d results still outstanding", test_name, exp_q.size());
            tb_faults++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_mark  = errors + tb_faults;
    endtask

    task automatic end_test();
        int n;
        n = errors + tb_faults - err_mark;
        tests_run++;
        if (n != 0) tests_failed++;
        $display("test %-16s %s (%0d errors)", test_name, (n == 0) ? "pass" : "fail", n);
    endtask

    // outputs read in the middle of the cycle
    always @(negedge clk) begin
        int   idx;
        logic rej_exp;
        idx     = -1;
        rej_exp = (rej_q.size() > 0) && (rej_q[0] == cyc);
        if (rej_exp) void'(rej_q.pop_front());
        if (reject === 1'b1) seen_rejects++;
        checks++;
        if (reject !== rej_exp) begin
            errors++;
            $display("Mismatch in %s: reject expected %b actual %b (cycle %0d)",
                     test_name, rej_exp, reject, cyc);
        end
        foreach (exp_q[i]) begin
            if (exp_q[i].due == cyc) idx = i;
        end
        checks++;
        if (idx >= 0) begin
            if (done !== 1'b1) begin
                errors++;
                $display("No done in %s at cycle %0d where a result was due", test_name, cyc);
            end else begin
                if (result_op !== exp_q[idx].op) begin
                    errors++;
                    $display("Mismatch in %s: result_op expected %0d actual %0d",
                             test_name, exp_q[idx].op, result_op);
                end
                if (result !== exp_q[idx].vec) begin
                    errors++;
                    $display("Mismatch in %s: result expected %h actual %h",
                             test_name, exp_q[idx].vec, result);
                end
            end
            exp_q.delete(idx);
        end else if (done !== 1'b0) begin
            errors++;
            $display("Unexpected done in %s at cycle %0d, nothing was due", test_name, cyc);
        end
    end

    initial begin
        vec3_t       va;
        vec3_t       vb;
        quat_t       q;
        logic [15:0] r;
        int          mark;
        arst_n   <= 1'b0;
        valid_in <= 1'b0;
        op       <= OP_SCALE;
        a        <= '0;
        b        <= '0;
        rot      <= '0;

        begin_test("reset");                         // done and reject stay low
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        repeat (6) @(posedge clk);
        end_test();

        begin_test("scale_translate");
        for (int n = 0; n < 12; n++) begin
            random_operands(va, vb, q);
            issue(OP_SCALE, va, vb, q);
            random_operands(va, vb, q);
            issue(OP_TRANSLATE, va, vb, q);
        end
        drain();
        end_test();

        begin_test("dot");
        for (int n = 0; n < 16; n++) begin
            random_operands(va, vb, q);
            issue(OP_DOT, va, vb, q);
        end
        drain();
        end_test();

        begin_test("rotate");
        va = '0;
        vb = '0;
        q  = '0;
        va[0] = 16'sd256;                            // unit x
        q[0]  = 16'sd181;                            // cos 45 deg
        q[3]  = 16'sd181;                            // sin 45 deg about z
        issue(OP_ROTATE, va, vb, q);
        for (int n = 0; n < 12; n++) begin
            random_operands(va, vb, q);
            issue(OP_ROTATE, va, vb, q);
        end
        drain();
        end_test();

        begin_test("collision");
        mark = seen_rejects;
        random_operands(va, vb, q);
        issue(OP_ROTATE, va, vb, q);
        repeat (LAT_ROT - LAT_ELEM - 1) idle_cycle();
        random_operands(va, vb, q);
        issue(OP_TRANSLATE, va, vb, q);              // lands on the rotate slot
        drain();
        if (seen_rejects != mark + 1) begin
            $display("Reject count in %s is %0d, the translate alone should be refused",
                     test_name, seen_rejects - mark);
            tb_faults++;
        end
        end_test();

        begin_test("mixed_stream");
        for (int n = 0; n < 64; n++) begin
            r = rand_bits(2);
            random_operands(va, vb, q);
            issue(xform_op_e'(r[1:0]), va, vb, q);
        end
        drain();
        end_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d rejects predicted",
                 tests_run, tests_failed, checks, errors + tb_faults, predicted_rejects);
        if (errors + tb_faults == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* hw/xform_unit.sv */
`timescale 1ns/1ps

module xform_unit #(
    parameter int MUL_STAGES = 2,                    // regs after each multiply
    parameter int ADD_STAGES = 1                     // regs after each adder level
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 valid_in,
    input  xform_pkg::xform_op_e op,
    input  xform_pkg::vec3_t     a,
    input  xform_pkg::vec3_t     b,
    input  xform_pkg::quat_t     rot,
    output logic                 done,
    output logic                 reject,
    output xform_pkg::xform_op_e result_op,
    output xform_pkg::vec3_t     result
);
    import xform_pkg::*;

    vec3_t  scale_out;
    vec3_t  translate_out;
    fix16_t dot_out;
    vec3_t  rotate_out;

    vec_elementwise #(
        .MUL_STAGES (MUL_STAGES),
        .ADD_STAGES (ADD_STAGES),
        .is_add     (1'b0)
    ) u_scale (
        .clk (clk),
        .a   (a),
        .b   (b),
        .y   (scale_out)
    );

    vec_elementwise #(
        .MUL_STAGES (MUL_STAGES),
        .ADD_STAGES (ADD_STAGES),
        .is_add     (1'b1)
    ) u_translate (
        .clk (clk),
        .a   (a),
        .b   (b),
        .y   (translate_out)
    );

    dot_product #(
        .MUL_STAGES (MUL_STAGES),
        .ADD_STAGES (ADD_STAGES)
    ) u_dot (
        .clk (clk),
        .a   (a),
        .b   (b),
        .y   (dot_out)
    );

    quat_rotate #(
        .MUL_STAGES (MUL_STAGES),
        .ADD_STAGES (ADD_STAGES)
    ) u_rotate (
        .clk (clk),
        .v   (a),                                    // rotates operand a
        .rot (rot),
        .y   (rotate_out)
    );

    xform_ctrl #(
        .MUL_STAGES (MUL_STAGES),
        .ADD_STAGES (ADD_STAGES)
    ) u_ctrl (
        .clk           (clk),
        .arst_n        (arst_n),
        .valid_in      (valid_in),
        .op            (op),
        .scale_out     (scale_out),
        .translate_out (translate_out),
        .dot_out       (dot_out),
        .rotate_out    (rotate_out),
        .done          (done),
        .reject        (reject),
        .result_op     (result_op),
        .result        (result)
    );

endmodule

/* hw/quat_rotate.sv */
`timescale 1ns/1ps

module quat_rotate #(
    parameter int MUL_STAGES = 2,
    parameter int ADD_STAGES = 1
) (
    input  logic             clk,
    input  xform_pkg::vec3_t v,
    input  xform_pkg::quat_t rot,
    output xform_pkg::vec3_t y
);
    import xform_pkg::*;

    localparam int LAT_QMUL = MUL_STAGES + 2 * ADD_STAGES;

    quat_t v_quat;                                   // (0, v)
    quat_t rot_v;                                    // rot * (0, v)
    quat_t conj_q [LAT_QMUL];                        // conj(rot), aligned with rot_v
    quat_t rot_v_conj;                               // rot * (0, v) * conj(rot)

    assign v_quat = quat_pure(v);

    quat_mult #(
        .MUL_STAGES (MUL_STAGES),
        .ADD_STAGES (ADD_STAGES)
    ) u_mult_first (
        .clk (clk),
        .p   (rot),
        .q   (v_quat),
        .c   (rot_v)
    );

    always_ff @(posedge clk) begin
        conj_q[0] <= quat_conj(rot);
        for (int s = 1; s < LAT_QMUL; s++) begin
            conj_q[s] <= conj_q[s-1];
        end
    end

    quat_mult #(
        .MUL_STAGES (MUL_STAGES),
        .ADD_STAGES (ADD_STAGES)
    ) u_mult_second (
        .clk (clk),
        .p   (rot_v),
        .q   (conj_q[LAT_QMUL-1]),
        .c   (rot_v_conj)
    );

    // real part is near zero only, truncation leaves a small residue there
    assign y[0] = rot_v_conj[1];
    assign y[1] = rot_v_conj[2];
    assign y[2] = rot_v_conj[3];

endmodule

/* hw/quat_mult.sv */
`timescale 1ns/1ps

module quat_mult #(
    parameter int MUL_STAGES = 2,
    parameter int ADD_STAGES = 1
) (
    input  logic             clk,
    input  xform_pkg::quat_t p,
    input  xform_pkg::quat_t q,
    output xform_pkg::quat_t c
);
    import xform_pkg::*;

    quat_t qp    [4];                                // q permuted for r, i, j, k rows
    quat_t prod  [4];                                // prod[row][n] = p[n] * qp[row][n]
    quat_t mul_q [MUL_STAGES][4];
    quat_t lo;                                       // first pair of each row
    quat_t hi;                                       // second pair of each row
    quat_t lo_q  [ADD_STAGES];
    quat_t hi_q  [ADD_STAGES];
    quat_t c_sum;
    quat_t c_q   [ADD_STAGES];

    always_comb begin
        qp[0] = q;                                   // r row: q0 q1 q2 q3
        qp[1][0] = q[1];                             // i row: q1 q0 q3 q2
        qp[1][1] = q[0];
        qp[1][2] = q[3];
        qp[1][3] = q[2];
        qp[2][0] = q[2];                             // j row: q2 q3 q0 q1
        qp[2][1] = q[3];
        qp[2][2] = q[0];
        qp[2][3] = q[1];
        qp[3][0] = q[3];                             // k row: q3 q2 q1 q0
        qp[3][1] = q[2];
        qp[3][2] = q[1];
        qp[3][3] = q[0];
        for (int r = 0; r < 4; r++) begin
            for (int n = 0; n < 4; n++) begin
                prod[r][n] = fix_mul(p[n], qp[r][n]);
            end
        end
    end

    always_comb begin
        lo[0] = mul_q[MUL_STAGES-1][0][0] - mul_q[MUL_STAGES-1][0][1];  // r1
        hi[0] = mul_q[MUL_STAGES-1][0][2] + mul_q[MUL_STAGES-1][0][3];  // r2
        lo[1] = mul_q[MUL_STAGES-1][1][0] + mul_q[MUL_STAGES-1][1][1];  // i1
        hi[1] = mul_q[MUL_STAGES-1][1][2] - mul_q[MUL_STAGES-1][1][3];  // i2
        lo[2] = mul_q[MUL_STAGES-1][2][0] - mul_q[MUL_STAGES-1][2][1];  // j1
        hi[2] = mul_q[MUL_STAGES-1][2][2] + mul_q[MUL_STAGES-1][2][3];  // j2
        lo[3] = mul_q[MUL_STAGES-1][3][0] + mul_q[MUL_STAGES-1][3][1];  // k1
        hi[3] = mul_q[MUL_STAGES-1][3][2] - mul_q[MUL_STAGES-1][3][3];  // k2
    end

    always_comb begin
        c_sum[0] = lo_q[ADD_STAGES-1][0] - hi_q[ADD_STAGES-1][0];      // cr = r1 - r2
        c_sum[1] = lo_q[ADD_STAGES-1][1] + hi_q[ADD_STAGES-1][1];      // ci = i1 + i2
        c_sum[2] = lo_q[ADD_STAGES-1][2] + hi_q[ADD_STAGES-1][2];      // cj = j1 + j2
        c_sum[3] = lo_q[ADD_STAGES-1][3] - hi_q[ADD_STAGES-1][3];      // ck = k1 - k2
    end

    always_ff @(posedge clk) begin
        mul_q[0] <= prod;
        for (int s = 1; s < MUL_STAGES; s++) begin
            mul_q[s] <= mul_q[s-1];
        end
    end

    always_ff @(posedge clk) begin
        lo_q[0] <= lo;
        hi_q[0] <= hi;
        c_q[0]  <= c_sum;
        for (int s = 1; s < ADD_STAGES; s++) begin
            lo_q[s] <= lo_q[s-1];
            hi_q[s] <= hi_q[s-1];
            c_q[s]  <= c_q[s-1];
        end
    end

    assign c = c_q[ADD_STAGES-1];

endmodule

/* hw/dot_product.sv */
`timescale 1ns/1ps

module dot_product #(
    parameter int MUL_STAGES = 2,
    parameter int ADD_STAGES = 1
) (
    input  logic              clk,
    input  xform_pkg::vec3_t  a,
    input  xform_pkg::vec3_t  b,
    output xform_pkg::fix16_t y
);
    import xform_pkg::*;

    vec3_t  prod;                                    // ax*bx, ay*by, az*bz
    vec3_t  mul_q [MUL_STAGES];
    fix16_t xy_sum;
    fix16_t xy_q  [ADD_STAGES];                      // first adder level
    fix16_t z_q   [ADD_STAGES];                      // z rides along with x+y
    fix16_t xyz_sum;
    fix16_t xyz_q [ADD_STAGES];

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            prod[i] = fix_mul(a[i], b[i]);
        end
    end

    assign xy_sum  = mul_q[MUL_STAGES-1][0] + mul_q[MUL_STAGES-1][1];
    assign xyz_sum = xy_q[ADD_STAGES-1] + z_q[ADD_STAGES-1];

    always_ff @(posedge clk) begin
        mul_q[0] <= prod;
        for (int s = 1; s < MUL_STAGES; s++) begin
            mul_q[s] <= mul_q[s-1];
        end
    end

    always_ff @(posedge clk) begin
        xy_q[0]  <= xy_sum;
        z_q[0]   <= mul_q[MUL_STAGES-1][2];
        xyz_q[0] <= xyz_sum;
        for (int s = 1; s < ADD_STAGES; s++) begin
            xy_q[s]  <= xy_q[s-1];
            z_q[s]   <= z_q[s-1];
            xyz_q[s] <= xyz_q[s-1];
        end
    end

    assign y = xyz_q[ADD_STAGES-1];                  // mul + 2 add levels

endmodule

/* hw/vec_elementwise.sv */
`timescale 1ns/1ps

module vec_elementwise #(
    parameter int MUL_STAGES = 2,
    parameter int ADD_STAGES = 1,
    parameter bit is_add     = 1'b0                  // 0 scale, 1 translate
) (
    input  logic             clk,
    input  xform_pkg::vec3_t a,
    input  xform_pkg::vec3_t b,
    output xform_pkg::vec3_t y
);
    import xform_pkg::*;

    // sum gets its own adder stages, the rest is padding up to the multiply depth
    localparam int OP_STAGES  = is_add ? ((ADD_STAGES < MUL_STAGES) ? ADD_STAGES : MUL_STAGES)
                                       : MUL_STAGES;
    localparam int PAD_STAGES = MUL_STAGES - OP_STAGES;

    vec3_t lane;                                     // raw per-lane result
    vec3_t op_q [OP_STAGES];

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            lane[i] = is_add ? a[i] + b[i]           // wraps at 16 bits
                             : fix_mul(a[i], b[i]);
        end
    end

    always_ff @(posedge clk) begin
        op_q[0] <= lane;
        for (int s = 1; s < OP_STAGES; s++) begin
            op_q[s] <= op_q[s-1];
        end
    end

    if (PAD_STAGES > 0) begin : g_pad
        vec3_t pad_q [PAD_STAGES];                   // translate delay to match scale

        always_ff @(posedge clk) begin
            pad_q[0] <= op_q[OP_STAGES-1];
            for (int s = 1; s < PAD_STAGES; s++) begin
                pad_q[s] <= pad_q[s-1];
            end
        end

        assign y = pad_q[PAD_STAGES-1];
    end else begin : g_nopad
        assign y = op_q[OP_STAGES-1];
    end

endmodule

/* hw/xform_ctrl.sv */
`timescale 1ns/1ps

module xform_ctrl #(
    parameter int MUL_STAGES = 2,
    parameter int ADD_STAGES = 1
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 valid_in,
    input  xform_pkg::xform_op_e op,
    input  xform_pkg::vec3_t     scale_out,
    input  xform_pkg::vec3_t     translate_out,
    input  xform_pkg::fix16_t    dot_out,
    input  xform_pkg::vec3_t     rotate_out,
    output logic                 done,
    output logic                 reject,
    output xform_pkg::xform_op_e result_op,
    output xform_pkg::vec3_t     result
);
    import xform_pkg::*;

    localparam int LAT_ELEM = MUL_STAGES;
    localparam int LAT_DOT  = MUL_STAGES + 2 * ADD_STAGES;
    localparam int LAT_QMUL = MUL_STAGES + 2 * ADD_STAGES;
    localparam int LAT_ROT  = 2 * LAT_QMUL;
    localparam int DEPTH    = LAT_ROT + 1;           // slot j = result reg edge j+1 ahead

    function automatic int lat_of(input xform_op_e o);
        case (o)
            OP_SCALE, OP_TRANSLATE: return LAT_ELEM;
            OP_DOT:                 return LAT_DOT;
            default:                return LAT_ROT;
        endcase
    endfunction

    logic [DEPTH-1:0] slot;                          // reserved completion edges
    logic [DEPTH-1:0] set_mask;
    int               lat_sel;
    logic             accept;
    logic [3:0]       ends;                          // per opcode, output ready now
    vec3_t            sel_vec;
    xform_op_e        sel_op;

    assign lat_sel = lat_of(op);
    assign reject  = valid_in && slot[lat_sel];      // completion edge already taken
    assign accept  = valid_in && !slot[lat_sel];

    always_comb begin
        set_mask = '0;
        if (accept) set_mask[lat_sel-1] = 1'b1;      // one edge closer after this clock
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot <= '0;
        end else begin
            slot <= (slot >> 1) | set_mask;
        end
    end

    for (genvar o = 0; o < 4; o++) begin : g_op
        localparam xform_op_e OPC = xform_op_e'(o);
        localparam int        L   = lat_of(OPC);
        logic [L-1:0] vp;                            // valid pipe, one bit per stage
        logic         issue;

        assign issue = accept && (op == OPC);

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                vp <= '0;
            end else begin
                vp <= (vp << 1) | L'(issue);
            end
        end

        assign ends[o] = vp[L-1];                    // datapath output valid this cycle
    end

    // slot reservation keeps the datapath outputs apart
    a_one_end: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(ends));

    // last reservation bit and the valid pipes name the same completion
    a_slot_end: assert property (@(posedge clk) disable iff (!arst_n)
        slot[0] == (|ends));

    always_comb begin
        sel_vec = '0;
        sel_op  = OP_SCALE;
        if (ends[OP_SCALE]) begin
            sel_vec = scale_out;
        end else if (ends[OP_TRANSLATE]) begin
            sel_vec = translate_out;
            sel_op  = OP_TRANSLATE;
        end else if (ends[OP_DOT]) begin
            sel_vec[0] = dot_out;                    // y and z stay zero
            sel_op     = OP_DOT;
        end else if (ends[OP_ROTATE]) begin
            sel_vec = rotate_out;
            sel_op  = OP_ROTATE;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else begin
            done <= |ends;
        end
    end

    always_ff @(posedge clk) begin
        if (|ends) begin                             // hold last result otherwise
            result    <= sel_vec;
            result_op <= sel_op;
        end
    end

endmodule

/* hw/xform_pkg.sv */
package xform_pkg;

    localparam int FRAC_BITS = 8;                    // q8.8 fraction width

    typedef logic signed [15:0] fix16_t;             // one q8.8 word

    typedef fix16_t [2:0] vec3_t;                    // [0]=x [1]=y [2]=z

    typedef fix16_t [3:0] quat_t;                    // [0]=r [1]=i [2]=j [3]=k

    typedef enum logic [1:0] {
        OP_SCALE     = 2'd0,                         // a * b per lane
        OP_TRANSLATE = 2'd1,                         // a + b per lane
        OP_DOT       = 2'd2,                         // a . b into lane x
        OP_ROTATE    = 2'd3                          // rot * (0,a) * conj(rot)
    } xform_op_e;

    // signed product, kept at full width, then shifted back down
    // to q8.8 and truncated to the low 16 bits
    function automatic fix16_t fix_mul(input fix16_t x, input fix16_t y);
        logic signed [31:0] full;                    // full precision product
        full = x * y;
        return full[FRAC_BITS +: 16];                // same as >>> then truncate
    endfunction

    // conjugate of a quaternion, real part kept, imaginary negated
    function automatic quat_t quat_conj(input quat_t q);
        quat_t c;
        c[0] = q[0];
        c[1] = -q[1];                                // wraps on -128.0
        c[2] = -q[2];
        c[3] = -q[3];
        return c;
    endfunction

    // pure quaternion (0, v)
    function automatic quat_t quat_pure(input vec3_t v);
        quat_t q;
        q[0] = '0;
        q[1] = v[0];
        q[2] = v[1];
        q[3] = v[2];
        return q;
    endfunction

endpackage
